//--- source/phv_format_pkg.sv
// fixed 1124-bit PHV layout with containers packed from the top and five comparator descriptors above 256 bits of metadata
package phv_format_pkg;

    localparam int CONT_COUNT = 8;
    localparam int CONT6_W = 48;
    localparam int CONT4_W = 32;
    localparam int CONT2_W = 16;
    localparam int COM_OP_COUNT = 5;
    localparam int COM_OP_W = 20;
    localparam int META_W = 256;
    localparam int PHV_LEN = CONT_COUNT * (CONT6_W + CONT4_W + CONT2_W)
                           + COM_OP_COUNT * COM_OP_W + META_W;

    // top bit of each container region
    localparam int CONT6_TOP = PHV_LEN - 1;
    localparam int CONT4_TOP = CONT6_TOP - CONT_COUNT * CONT6_W;
    localparam int CONT2_TOP = CONT4_TOP - CONT_COUNT * CONT4_W;
    // descriptor 0 sits just below the 2B containers, at 355
    localparam int COM_OP_TOP = META_W + COM_OP_COUNT * COM_OP_W - 1;
    localparam int TENANT_LSB = 133;

    // comparator descriptor fields
    localparam int CMP_FN_LSB = 18;
    localparam int OPA_IMM_BIT = 17;
    localparam int OPA_LSB = 9;
    localparam int OPB_IMM_BIT = 8;
    localparam int OPB_LSB = 0;

    localparam int KEY_LEN = 2 * (CONT6_W + CONT4_W + CONT2_W) + COM_OP_COUNT;

    typedef logic [PHV_LEN-1:0] phv_t;
    typedef logic [CONT6_W-1:0] cont6_t;
    typedef logic [CONT4_W-1:0] cont4_t;
    typedef logic [CONT2_W-1:0] cont2_t;
    typedef logic [$clog2(CONT_COUNT)-1:0] cont_sel_t;
    typedef enum logic [1:0] {
        kind_2b = 2'b00,
        kind_4b = 2'b01,
        kind_6b = 2'b10,
        kind_none = 2'b11
    } cont_kind_t;
    typedef logic [COM_OP_W-1:0] com_op_t;
    typedef enum logic [1:0] {cmp_gt, cmp_ge, cmp_eq, cmp_true} cmp_fn_t;
    typedef logic [7:0] operand_t;
    typedef logic [KEY_LEN-1:0] key_t;
    typedef logic [3:0] tenant_t;

endpackage

//--- source/ctrl_format_pkg.sv
// 512-bit control beats only; header fields sit at fixed bit positions of the first beat
package ctrl_format_pkg;

    localparam int CTRL_WIDTH = 512;
    typedef logic [CTRL_WIDTH-1:0] ctrl_data_t;

    // upper bits name the stage, lower bits the extractor
    typedef logic [7:0] mod_id_t;
    localparam int EXT_ID_W = 3;

    localparam int MOD_ID_LSB = 368;
    // zero selects the offset table
    localparam int TBL_SEL_LSB = 376;
    localparam int TBL_SEL_W = 4;
    localparam int FLAG_LSB = 320;
    localparam int FLAG_W = 16;
    localparam int IDX_LSB = 384;
    localparam int IDX_W = 8;

    localparam logic [FLAG_W-1:0] CTRL_FLAG = 16'hf2f1;

    // six 3-bit container indices, 6B fields first
    localparam int OFF_ENTRY_W = 18;
    localparam int MASK_ENTRY_W = 197;

    typedef logic [OFF_ENTRY_W-1:0] off_entry_t;
    typedef logic [MASK_ENTRY_W-1:0] mask_entry_t;

endpackage

//--- source/key_table_ram.sv
// registered read returns the old entry on a same-address write; contents are unknown until written
`timescale 1ns/1ps

module key_table_ram #(
    parameter int  ENTRY_WIDTH = 18,
    parameter int  TABLE_DEPTH = 16,
    localparam int ADDR_W = $clog2(TABLE_DEPTH)
) (
    input  logic                   clk,
    input  logic                   wr_en,
    input  logic [ADDR_W-1:0]      wr_addr,
    input  logic [ENTRY_WIDTH-1:0] wr_data,
    input  logic [ADDR_W-1:0]      rd_addr,
    output logic [ENTRY_WIDTH-1:0] rd_data
);

    logic [ENTRY_WIDTH-1:0] mem [TABLE_DEPTH];

    // write port from the config FSM
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port from the PHV path, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- source/table_config_fsm.sv
// no back-pressure on the control stream; table index wraps at 16 and a header-only table packet writes nothing
`timescale 1ns/1ps

module table_config_fsm
    import phv_format_pkg::*;
    import ctrl_format_pkg::*;
#(
    parameter int STAGE_ID = 0,
    parameter int KEY_EX_ID = 0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  ctrl_data_t  c_s_tdata,
    input  logic        c_s_tvalid,
    input  logic        c_s_tlast,
    output ctrl_data_t  c_m_tdata,
    output logic        c_m_tvalid,
    output logic        c_m_tlast,
    output logic        off_wr_en,
    output logic        mask_wr_en,
    output tenant_t     wr_addr,
    output off_entry_t  off_wr_data,
    output mask_entry_t mask_wr_data
);

    localparam mod_id_t OWN_ID = mod_id_t'((STAGE_ID << EXT_ID_W) | KEY_EX_ID);

    typedef enum logic [1:0] {idle, pass, load_offset, load_mask} state_t;

    state_t               state;
    tenant_t              next_idx;
    mod_id_t              mod_id;
    logic [TBL_SEL_W-1:0] tbl_sel;
    logic [FLAG_W-1:0]    flag;
    logic [IDX_W-1:0]     start_idx;
    logic                 is_table;
    logic                 entry_beat;
    ctrl_data_t           swapped;

    // header fields, only meaningful on the first beat
    assign mod_id = c_s_tdata[MOD_ID_LSB +: $bits(mod_id_t)];
    assign tbl_sel = c_s_tdata[TBL_SEL_LSB +: TBL_SEL_W];
    assign flag = c_s_tdata[FLAG_LSB +: FLAG_W];
    assign start_idx = c_s_tdata[IDX_LSB +: IDX_W];
    assign is_table = (mod_id == OWN_ID) && (flag == CTRL_FLAG);

    assign entry_beat = c_s_tvalid && (state == load_offset || state == load_mask);

    // entries arrive little endian, reverse the 64 bytes
    always_comb begin
        for (int b = 0; b < CTRL_WIDTH / 8; b++) begin
            swapped[b*8 +: 8] = c_s_tdata[CTRL_WIDTH-8-b*8 +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            next_idx <= '0;
            off_wr_en <= 1'b0;
            mask_wr_en <= 1'b0;
            c_m_tvalid <= 1'b0;
            c_m_tlast <= 1'b0;
        end else begin
            off_wr_en <= 1'b0;
            mask_wr_en <= 1'b0;
            c_m_tvalid <= 1'b0;
            c_m_tlast <= 1'b0;
            case (state)
                idle: begin
                    if (c_s_tvalid && is_table) begin
                        next_idx <= start_idx[$bits(tenant_t)-1:0];
                        if (!c_s_tlast) begin
                            state <= (tbl_sel == '0) ? load_offset : load_mask;
                        end
                    end else if (c_s_tvalid) begin
                        // foreign header goes straight out
                        c_m_tvalid <= 1'b1;
                        c_m_tlast <= c_s_tlast;
                        if (!c_s_tlast) begin
                            state <= pass;
                        end
                    end
                end
                pass: begin
                    // body beats are forwarded without decoding
                    if (c_s_tvalid) begin
                        c_m_tvalid <= 1'b1;
                        c_m_tlast <= c_s_tlast;
                        if (c_s_tlast) begin
                            state <= idle;
                        end
                    end
                end
                load_offset, load_mask: begin
                    if (c_s_tvalid) begin
                        off_wr_en <= (state == load_offset);
                        mask_wr_en <= (state == load_mask);
                        next_idx <= next_idx + 1'b1;
                        if (c_s_tlast) begin
                            state <= idle;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        c_m_tdata <= c_s_tdata;
        if (entry_beat) begin
            wr_addr <= next_idx;
            off_wr_data <= swapped[CTRL_WIDTH-1 -: OFF_ENTRY_W];
            mask_wr_data <= swapped[CTRL_WIDTH-1 -: MASK_ENTRY_W];
        end
    end

endmodule

//--- source/phv_pipeline.sv
// three register stages; table read data must arrive one cycle after the PHV that addressed it
`timescale 1ns/1ps

module phv_pipeline
    import phv_format_pkg::*;
    import ctrl_format_pkg::*;
#(
    parameter int STAGE_ID = 0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  phv_t        phv_in,
    input  logic        phv_valid_in,
    input  off_entry_t  off_rd,
    input  mask_entry_t mask_rd,
    output cont6_t      cont6 [CONT_COUNT],
    output cont4_t      cont4 [CONT_COUNT],
    output cont2_t      cont2 [CONT_COUNT],
    output com_op_t     com_op,
    output logic        slot_valid,
    output phv_t        phv_slot,
    output off_entry_t  off_slot,
    output mask_entry_t mask_slot
);

    // this stage's descriptor
    localparam int COM_OP_MSB = COM_OP_TOP - COM_OP_W * STAGE_ID;

    phv_t        phv_d0;
    phv_t        phv_d1;
    logic        valid_d0;
    logic        valid_d1;
    off_entry_t  off_d1;
    mask_entry_t mask_d1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d0 <= 1'b0;
            valid_d1 <= 1'b0;
            slot_valid <= 1'b0;
        end else begin
            valid_d0 <= phv_valid_in;
            valid_d1 <= valid_d0;
            slot_valid <= valid_d1;
        end
    end

    always_ff @(posedge clk) begin
        phv_d0 <= phv_in;
        phv_d1 <= phv_d0;
        phv_slot <= phv_d1;
    end

    // read data lines up with phv_d0, two more stages to reach the slot
    always_ff @(posedge clk) begin
        off_d1 <= off_rd;
        off_slot <= off_d1;
        mask_d1 <= mask_rd;
        mask_slot <= mask_d1;
    end

    // container 7 of each size sits at the top of its region
    always_ff @(posedge clk) begin
        for (int i = 0; i < CONT_COUNT; i++) begin
            cont6[i] <= phv_d1[CONT6_TOP - (CONT_COUNT-1-i)*CONT6_W -: CONT6_W];
            cont4[i] <= phv_d1[CONT4_TOP - (CONT_COUNT-1-i)*CONT4_W -: CONT4_W];
            cont2[i] <= phv_d1[CONT2_TOP - (CONT_COUNT-1-i)*CONT2_W -: CONT2_W];
        end
        com_op <= phv_d1[COM_OP_MSB -: COM_OP_W];
    end

endmodule

//--- source/predicate_eval.sv
// purely combinational; operands compare as unsigned bytes and the unused kind code reads as zero
`timescale 1ns/1ps

module predicate_eval
    import phv_format_pkg::*;
(
    input  cont6_t  cont6 [CONT_COUNT],
    input  cont4_t  cont4 [CONT_COUNT],
    input  cont2_t  cont2 [CONT_COUNT],
    input  com_op_t com_op,
    output logic    predicate
);

    // kind bits above the container index
    localparam int SRC_W = 2 + $bits(cont_sel_t);
    localparam int OPND_W = $bits(operand_t);

    operand_t opa;
    operand_t opb;
    cmp_fn_t  fn;

    // low byte of the container named by a source field
    function automatic operand_t cont_byte(input logic [SRC_W-1:0] src);
        cont_kind_t kind;
        cont_sel_t  sel;
        kind = cont_kind_t'(src[SRC_W-1 -: 2]);
        sel = src[$bits(cont_sel_t)-1:0];
        case (kind)
            kind_6b: cont_byte = cont6[sel][OPND_W-1:0];
            kind_4b: cont_byte = cont4[sel][OPND_W-1:0];
            kind_2b: cont_byte = cont2[sel][OPND_W-1:0];
            default: cont_byte = '0;
        endcase
    endfunction

    always_comb begin
        opa = com_op[OPA_IMM_BIT] ? com_op[OPA_LSB +: OPND_W] : cont_byte(com_op[OPA_LSB +: SRC_W]);
        opb = com_op[OPB_IMM_BIT] ? com_op[OPB_LSB +: OPND_W] : cont_byte(com_op[OPB_LSB +: SRC_W]);
        fn = cmp_fn_t'(com_op[CMP_FN_LSB +: 2]);
        case (fn)
            cmp_gt: predicate = (opa > opb);
            cmp_ge: predicate = (opa >= opb);
            cmp_eq: predicate = (opa == opb);
            default: predicate = 1'b1;
        endcase
    end

endmodule

//--- source/key_assembler.sv
// key_mask_out follows every slot and is only meaningful while key_valid_out is high
`timescale 1ns/1ps

module key_assembler
    import phv_format_pkg::*;
    import ctrl_format_pkg::*;
#(
    parameter int STAGE_ID = 0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  cont6_t      cont6 [CONT_COUNT],
    input  cont4_t      cont4 [CONT_COUNT],
    input  cont2_t      cont2 [CONT_COUNT],
    input  logic        predicate,
    input  logic        slot_valid,
    input  phv_t        phv_slot,
    input  off_entry_t  off_slot,
    input  mask_entry_t mask_slot,
    output key_t        key_out,
    output logic        key_valid_out,
    output mask_entry_t key_mask_out,
    output phv_t        phv_out,
    output logic        phv_valid_out
);

    localparam int SEL_W = $bits(cont_sel_t);
    localparam int KEY_FIELDS = OFF_ENTRY_W / SEL_W;
    // stage 0 owns the highest predicate bit
    localparam int PRED_BIT = COM_OP_COUNT - 1 - STAGE_ID;

    cont_sel_t sel [KEY_FIELDS];
    key_t      key_next;

    // offset entry holds the indices in key field order, first field on top
    always_comb begin
        for (int f = 0; f < KEY_FIELDS; f++) begin
            sel[f] = off_slot[OFF_ENTRY_W-1-f*SEL_W -: SEL_W];
        end
    end

    always_comb begin
        key_next = {cont6[sel[0]], cont6[sel[1]], cont4[sel[2]], cont4[sel[3]],
                    cont2[sel[4]], cont2[sel[5]], {COM_OP_COUNT{1'b0}}};
        key_next[PRED_BIT] = predicate;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_out <= '0;
            key_valid_out <= 1'b0;
            phv_valid_out <= 1'b0;
        end else begin
            key_out <= slot_valid ? key_next : '0;
            key_valid_out <= slot_valid;
            phv_valid_out <= slot_valid;
        end
    end

    always_ff @(posedge clk) begin
        phv_out <= phv_slot;
        key_mask_out <= mask_slot;
    end

endmodule

//--- source/key_extract_top.sv
// tables must be configured before traffic; outputs appear 4 cycles after phv_valid_in
`timescale 1ns/1ps

module key_extract_top
    import phv_format_pkg::*;
    import ctrl_format_pkg::*;
#(
    parameter int STAGE_ID = 0,
    parameter int KEY_EX_ID = 1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  phv_t        phv_in,
    input  logic        phv_valid_in,
    output phv_t        phv_out,
    output logic        phv_valid_out,
    output key_t        key_out,
    output logic        key_valid_out,
    output mask_entry_t key_mask_out,
    input  ctrl_data_t  c_s_tdata,
    input  logic        c_s_tvalid,
    input  logic        c_s_tlast,
    output ctrl_data_t  c_m_tdata,
    output logic        c_m_tvalid,
    output logic        c_m_tlast
);

    // one entry per tenant
    localparam int TABLE_DEPTH = 2 ** $bits(tenant_t);

    tenant_t     rd_addr;
    tenant_t     wr_addr;
    logic        off_wr_en;
    logic        mask_wr_en;
    off_entry_t  off_wr_data;
    mask_entry_t mask_wr_data;
    off_entry_t  off_rd;
    mask_entry_t mask_rd;
    off_entry_t  off_slot;
    mask_entry_t mask_slot;
    cont6_t      cont6 [CONT_COUNT];
    cont4_t      cont4 [CONT_COUNT];
    cont2_t      cont2 [CONT_COUNT];
    com_op_t     com_op;
    logic        slot_valid;
    phv_t        phv_slot;
    logic        predicate;

    assign rd_addr = phv_in[TENANT_LSB +: $bits(tenant_t)];

    table_config_fsm #(.STAGE_ID(STAGE_ID), .KEY_EX_ID(KEY_EX_ID)) config_fsm (
        .clk(clk), .rst_n(rst_n),
        .c_s_tdata(c_s_tdata), .c_s_tvalid(c_s_tvalid), .c_s_tlast(c_s_tlast),
        .c_m_tdata(c_m_tdata), .c_m_tvalid(c_m_tvalid), .c_m_tlast(c_m_tlast),
        .off_wr_en(off_wr_en), .mask_wr_en(mask_wr_en), .wr_addr(wr_addr),
        .off_wr_data(off_wr_data), .mask_wr_data(mask_wr_data)
    );

    key_table_ram #(.ENTRY_WIDTH(OFF_ENTRY_W), .TABLE_DEPTH(TABLE_DEPTH)) offset_table (
        .clk(clk), .wr_en(off_wr_en), .wr_addr(wr_addr), .wr_data(off_wr_data),
        .rd_addr(rd_addr), .rd_data(off_rd)
    );

    key_table_ram #(.ENTRY_WIDTH(MASK_ENTRY_W), .TABLE_DEPTH(TABLE_DEPTH)) mask_table (
        .clk(clk), .wr_en(mask_wr_en), .wr_addr(wr_addr), .wr_data(mask_wr_data),
        .rd_addr(rd_addr), .rd_data(mask_rd)
    );

    phv_pipeline #(.STAGE_ID(STAGE_ID)) pipeline (
        .clk(clk), .rst_n(rst_n), .phv_in(phv_in), .phv_valid_in(phv_valid_in),
        .off_rd(off_rd), .mask_rd(mask_rd),
        .cont6(cont6), .cont4(cont4), .cont2(cont2), .com_op(com_op),
        .slot_valid(slot_valid), .phv_slot(phv_slot),
        .off_slot(off_slot), .mask_slot(mask_slot)
    );

    predicate_eval pred (
        .cont6(cont6), .cont4(cont4), .cont2(cont2), .com_op(com_op), .predicate(predicate)
    );

    key_assembler #(.STAGE_ID(STAGE_ID)) assembler (
        .clk(clk), .rst_n(rst_n), .cont6(cont6), .cont4(cont4), .cont2(cont2),
        .predicate(predicate), .slot_valid(slot_valid), .phv_slot(phv_slot),
        .off_slot(off_slot), .mask_slot(mask_slot),
        .key_out(key_out), .key_valid_out(key_valid_out), .key_mask_out(key_mask_out),
        .phv_out(phv_out), .phv_valid_out(phv_valid_out)
    );

endmodule

//--- testbench/tb_key_extract.sv
// runs stage 2, extractor 1 only; container low bytes are planted so the predicate table stays fixed
`timescale 1ns/1ps

module tb_key_extract
    import phv_format_pkg::*;
    import ctrl_format_pkg::*;
();

    localparam int STAGE = 2;
    localparam int KEY_EX = 1;
    localparam int CLK_PERIOD = 20;
    localparam int N_ENTRIES = 8;
    localparam int START_IDX = 3;
    localparam int ENTRY_BUDGET = 25;
    localparam int MARGIN = 100;
    // PHV layout: 6B, 4B and 2B regions from the top, container 0 lowest in each
    localparam int CONT6_BASE = PHV_LEN - 8 * 48;
    localparam int CONT4_BASE = CONT6_BASE - 8 * 32;
    localparam int CONT2_BASE = CONT4_BASE - 8 * 16;
    localparam int TENANT_POS = 133;
    localparam int DESC_MSB = 355 - 20 * STAGE;
    localparam int PRED_POS = 4 - STAGE;

    typedef logic [PHV_LEN-1:0] value_t;

    logic        clk;
    logic        rst_n;
    phv_t        phv_in;
    logic        phv_valid_in;
    phv_t        phv_out;
    logic        phv_valid_out;
    key_t        key_out;
    logic        key_valid_out;
    mask_entry_t key_mask_out;
    ctrl_data_t  c_s_tdata;
    logic        c_s_tvalid;
    logic        c_s_tlast;
    ctrl_data_t  c_m_tdata;
    logic        c_m_tvalid;
    logic        c_m_tlast;

    logic [31:0] lfsr_state;

    // test table, tenant k+START_IDX holds entry k
    tenant_t     tbl_tenant [N_ENTRIES];
    off_entry_t  tbl_off [N_ENTRIES];
    mask_entry_t tbl_mask [N_ENTRIES];
    com_op_t     tbl_desc [N_ENTRIES];
    logic        tbl_pred [N_ENTRIES];

    key_extract_top #(.STAGE_ID(STAGE), .KEY_EX_ID(KEY_EX)) uut (
        .clk(clk), .rst_n(rst_n),
        .phv_in(phv_in), .phv_valid_in(phv_valid_in),
        .phv_out(phv_out), .phv_valid_out(phv_valid_out),
        .key_out(key_out), .key_valid_out(key_valid_out), .key_mask_out(key_mask_out),
        .c_s_tdata(c_s_tdata), .c_s_tvalid(c_s_tvalid), .c_s_tlast(c_s_tlast),
        .c_m_tdata(c_m_tdata), .c_m_tvalid(c_m_tvalid), .c_m_tlast(c_m_tlast)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((N_ENTRIES * ENTRY_BUDGET + MARGIN) * CLK_PERIOD);
        $display("Error: %0t ns: watchdog expired, the tests did not finish in time", $time);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog timeout");
    end

    task automatic check_value(input string what, input value_t got, input value_t expected);
        if (got !== expected) begin
            $display("Error: %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_vector(input int nbits, output value_t v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v[i] = lfsr_state[0];
        end
    endtask

    function automatic ctrl_data_t byte_reverse(input ctrl_data_t d);
        ctrl_data_t r;
        for (int b = 0; b < CTRL_WIDTH / 8; b++) begin
            r[b*8 +: 8] = d[CTRL_WIDTH-8-b*8 +: 8];
        end
        return r;
    endfunction

    function automatic com_op_t make_desc(input cmp_fn_t fn, input logic a_imm, input operand_t a,
                                          input logic b_imm, input operand_t b);
        return {fn, a_imm, a, b_imm, b};
    endfunction

    // operand field naming a container instead of an immediate
    function automatic operand_t cont_src(input cont_kind_t kind, input logic [2:0] idx);
        return {3'b000, kind, idx};
    endfunction

    function automatic cont6_t cont6_at(input phv_t p, input logic [2:0] idx);
        return p[CONT6_BASE + int'(idx) * 48 +: 48];
    endfunction

    function automatic cont4_t cont4_at(input phv_t p, input logic [2:0] idx);
        return p[CONT4_BASE + int'(idx) * 32 +: 32];
    endfunction

    function automatic cont2_t cont2_at(input phv_t p, input logic [2:0] idx);
        return p[CONT2_BASE + int'(idx) * 16 +: 16];
    endfunction

    function automatic key_t expected_key(input phv_t p, input off_entry_t off, input logic pred);
        key_t k;
        k = {cont6_at(p, off[17:15]), cont6_at(p, off[14:12]), cont4_at(p, off[11:9]),
             cont4_at(p, off[8:6]), cont2_at(p, off[5:3]), cont2_at(p, off[2:0]), 5'b00000};
        k[PRED_POS] = pred;
        return k;
    endfunction

    // low bytes: 6B container i reads 8'h60+i, 4B 8'h40+i, 2B 8'h20+i
    task automatic build_table();
        value_t v;
        tbl_off[0] = {3'd0, 3'd7, 3'd1, 3'd6, 3'd2, 3'd5};
        tbl_desc[0] = make_desc(cmp_gt, 1'b1, 8'h50, 1'b1, 8'h40);
        tbl_pred[0] = 1'b1;
        tbl_off[1] = {3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6};
        tbl_desc[1] = make_desc(cmp_gt, 1'b0, cont_src(kind_4b, 3'd2), 1'b1, 8'h42);
        tbl_pred[1] = 1'b0;
        tbl_off[2] = {3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2};
        tbl_desc[2] = make_desc(cmp_ge, 1'b0, cont_src(kind_6b, 3'd5), 1'b0, cont_src(kind_2b, 3'd7));
        tbl_pred[2] = 1'b1;
        tbl_off[3] = {3'd3, 3'd3, 3'd0, 3'd7, 3'd6, 3'd1};
        tbl_desc[3] = make_desc(cmp_ge, 1'b1, 8'h10, 1'b0, cont_src(kind_6b, 3'd0));
        tbl_pred[3] = 1'b0;
        tbl_off[4] = {3'd4, 3'd0, 3'd2, 3'd2, 3'd7, 3'd0};
        tbl_desc[4] = make_desc(cmp_eq, 1'b0, cont_src(kind_2b, 3'd3), 1'b1, 8'h23);
        tbl_pred[4] = 1'b1;
        tbl_off[5] = {3'd5, 3'd1, 3'd7, 3'd0, 3'd1, 3'd7};
        tbl_desc[5] = make_desc(cmp_eq, 1'b0, cont_src(kind_4b, 3'd1), 1'b0, cont_src(kind_4b, 3'd6));
        tbl_pred[5] = 1'b0;
        tbl_off[6] = {3'd6, 3'd4, 3'd4, 3'd1, 3'd0, 3'd3};
        tbl_desc[6] = make_desc(cmp_true, 1'b0, cont_src(kind_none, 3'd0), 1'b1, 8'hff);
        tbl_pred[6] = 1'b1;
        // unused kind code reads as zero
        tbl_off[7] = {3'd2, 3'd5, 3'd6, 3'd3, 3'd4, 3'd4};
        tbl_desc[7] = make_desc(cmp_eq, 1'b0, cont_src(kind_none, 3'd5), 1'b1, 8'h00);
        tbl_pred[7] = 1'b1;
        for (int k = 0; k < N_ENTRIES; k++) begin
            tbl_tenant[k] = tenant_t'(START_IDX + k);
            random_vector(MASK_ENTRY_W, v);
            tbl_mask[k] = v[MASK_ENTRY_W-1:0];
        end
    endtask

    // called at a falling edge, returns at the next one after checking the output
    task automatic send_beat(input ctrl_data_t data, input logic last, input logic forwarded);
        c_s_tdata = data;
        c_s_tvalid = 1'b1;
        c_s_tlast = last;
        @(negedge clk);
        check_value("c_m_tvalid", value_t'(c_m_tvalid), value_t'(forwarded));
        if (forwarded) begin
            check_value("c_m_tdata", value_t'(c_m_tdata), value_t'(data));
            check_value("c_m_tlast", value_t'(c_m_tlast), value_t'(last));
        end
    endtask

    task automatic idle_cycle();
        c_s_tvalid = 1'b0;
        c_s_tlast = 1'b0;
        @(negedge clk);
        check_value("c_m_tvalid when idle", value_t'(c_m_tvalid), value_t'(1'b0));
    endtask

    task automatic make_header(input mod_id_t id, input logic [15:0] flag, input logic [3:0] sel,
                               output ctrl_data_t hdr);
        value_t v;
        random_vector(CTRL_WIDTH, v);
        hdr = v[CTRL_WIDTH-1:0];
        hdr[MOD_ID_LSB +: 8] = id;
        hdr[FLAG_LSB +: 16] = flag;
        hdr[TBL_SEL_LSB +: 4] = sel;
        hdr[IDX_LSB +: 8] = 8'(START_IDX);
    endtask

    task automatic write_table(input logic is_mask);
        ctrl_data_t hdr;
        ctrl_data_t body;
        value_t v;
        make_header(mod_id_t'(STAGE * 8 + KEY_EX), CTRL_FLAG, {3'b000, is_mask}, hdr);
        send_beat(hdr, 1'b0, 1'b0);
        for (int k = 0; k < N_ENTRIES; k++) begin
            random_vector(CTRL_WIDTH, v);
            body = v[CTRL_WIDTH-1:0];
            if (is_mask) begin
                body[CTRL_WIDTH-1 -: MASK_ENTRY_W] = tbl_mask[k];
            end else begin
                body[CTRL_WIDTH-1 -: OFF_ENTRY_W] = tbl_off[k];
            end
            send_beat(byte_reverse(body), k == N_ENTRIES - 1, 1'b0);
        end
        idle_cycle();
    endtask

    // the first body beat looks like an offset header for this stage
    task automatic send_foreign(input mod_id_t id, input logic [15:0] flag, input int nbeats);
        ctrl_data_t beat;
        value_t v;
        make_header(id, flag, 4'h0, beat);
        send_beat(beat, nbeats == 1, 1'b1);
        for (int b = 1; b < nbeats; b++) begin
            if (b == 1) begin
                make_header(mod_id_t'(STAGE * 8 + KEY_EX), CTRL_FLAG, 4'h0, beat);
            end else begin
                random_vector(CTRL_WIDTH, v);
                beat = v[CTRL_WIDTH-1:0];
            end
            send_beat(beat, b == nbeats - 1, 1'b1);
        end
        idle_cycle();
    endtask

    task automatic make_phv(input int e, output phv_t p);
        value_t v;
        random_vector(PHV_LEN, v);
        p = v;
        for (int i = 0; i < 8; i++) begin
            p[CONT6_BASE + i * 48 +: 8] = 8'h60 + 8'(i);
            p[CONT4_BASE + i * 32 +: 8] = 8'h40 + 8'(i);
            p[CONT2_BASE + i * 16 +: 8] = 8'h20 + 8'(i);
        end
        p[TENANT_POS +: 4] = tbl_tenant[e];
        p[DESC_MSB -: 20] = tbl_desc[e];
    endtask

    // PHV k enters at cycle k*spacing, every cycle checks the slot that entered 4 cycles before
    task automatic run_traffic(input int spacing, input logic reverse);
        phv_t        exp_phv [N_ENTRIES];
        key_t        exp_key [N_ENTRIES];
        mask_entry_t exp_mask [N_ENTRIES];
        phv_t        p;
        int          slot;
        int          k;
        int          e;
        for (int c = 0; c <= (N_ENTRIES - 1) * spacing + 5; c++) begin
            @(negedge clk);
            slot = c - 4;
            if (slot >= 0 && slot % spacing == 0 && slot / spacing < N_ENTRIES) begin
                k = slot / spacing;
                check_value("phv_valid_out", value_t'(phv_valid_out), value_t'(1'b1));
                check_value("key_valid_out", value_t'(key_valid_out), value_t'(1'b1));
                check_value("phv_out", value_t'(phv_out), value_t'(exp_phv[k]));
                check_value("key_out", value_t'(key_out), value_t'(exp_key[k]));
                check_value("key_mask_out", value_t'(key_mask_out), value_t'(exp_mask[k]));
            end else begin
                check_value("phv_valid_out", value_t'(phv_valid_out), value_t'(1'b0));
                check_value("key_valid_out", value_t'(key_valid_out), value_t'(1'b0));
                check_value("key_out of empty slot", value_t'(key_out), '0);
            end
            if (c % spacing == 0 && c / spacing < N_ENTRIES) begin
                k = c / spacing;
                e = reverse ? N_ENTRIES - 1 - k : k;
                make_phv(e, p);
                exp_phv[k] = p;
                exp_key[k] = expected_key(p, tbl_off[e], tbl_pred[e]);
                exp_mask[k] = tbl_mask[e];
                phv_in = p;
                phv_valid_in = 1'b1;
            end else begin
                phv_valid_in = 1'b0;
            end
        end
    endtask

    initial begin
        lfsr_state = 32'h9e4afbdb;
        rst_n = 1'b0;
        phv_in = '0;
        phv_valid_in = 1'b0;
        c_s_tdata = '0;
        c_s_tvalid = 1'b0;
        c_s_tlast = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("phv_valid_out after reset", value_t'(phv_valid_out), value_t'(1'b0));
        check_value("key_valid_out after reset", value_t'(key_valid_out), value_t'(1'b0));
        check_value("c_m_tvalid after reset", value_t'(c_m_tvalid), value_t'(1'b0));
        check_value("key_out after reset", value_t'(key_out), '0);
        rst_n = 1'b1;
        @(negedge clk);
        // offset packet last, a stray mask write from it would corrupt the masks
        write_table(1'b1);
        write_table(1'b0);
        // wrong stage, wrong extractor, wrong flag, then a single-beat packet
        send_foreign(mod_id_t'(3 * 8 + KEY_EX), CTRL_FLAG, 4);
        send_foreign(mod_id_t'(STAGE * 8 + 4), CTRL_FLAG, 3);
        send_foreign(mod_id_t'(STAGE * 8 + KEY_EX), 16'hf2f0, 5);
        send_foreign(mod_id_t'(0), CTRL_FLAG, 1);
        run_traffic(5, 1'b0);
        run_traffic(1, 1'b1);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- flist.f
source/phv_format_pkg.sv
source/ctrl_format_pkg.sv
source/key_table_ram.sv
source/table_config_fsm.sv
source/phv_pipeline.sv
source/predicate_eval.sv
source/key_assembler.sv
source/key_extract_top.sv
testbench/tb_key_extract.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
# the exit status is nonzero when the build fails or the testbench stops on $fatal

cd "$(dirname "$0")" \
    && verilator --binary --timing -j 0 \
        --top-module tb_key_extract \
        -f flist.f \
        -o sim_key_extract \
    && ./obj_dir/sim_key_extract \
    || exit 1
